//--- compile.f
dbg_pkg.sv
dii_packet_buffer.sv
him_ingress.sv
him_egress.sv
osd_him.sv
osd_him_assert.sv
tb_osd_him.sv

//--- tb_osd_him.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for osd_him with MAX_PKT_LEN 12, random traffic both ways.
// inputs change on the falling edge, outputs are sampled on the rising edge.
// packets stay within 1 .. 12 words, as the DUT requires.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_osd_him import dbg_pkg::*;;

  localparam int MAX_PKT_LEN = 12;
  localparam int WAIT_LIMIT  = 1000; // cycles per handshake.
  localparam int DRAIN_LIMIT = 4000; // cycles for the final drain.

  logic         clk;
  logic         rst;
  host_stream_t host_in;
  logic         host_in_ready;
  host_stream_t host_out;
  logic         host_out_ready;
  dii_flit_t    dii_out;
  logic         dii_out_ready;
  dii_flit_t    dii_in;
  logic         dii_in_ready;

  integer      seed = 32'hea5e651e;
  logic [16:0] ing_q [$];  // expected dii_out flits, {last, data}.
  logic [15:0] egr_q [$];  // expected host_out words, size then payload.
  logic [16:0] exp_flit;
  logic [15:0] exp_word;
  logic        host_in_acc; // host_in word taken at the last rising edge.
  logic        dii_in_acc;  // dii_in flit taken at the last rising edge.
  logic        rst_prev;
  int          ready_mode;  // 0 always ready, 1 random, 2 random with long stalls.
  int          stall_ing;
  int          stall_egr;
  int          waited;

  osd_him #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .host_in       (host_in),
    .host_in_ready (host_in_ready),
    .host_out      (host_out),
    .host_out_ready(host_out_ready),
    .dii_out       (dii_out),
    .dii_out_ready (dii_out_ready),
    .dii_in        (dii_in),
    .dii_in_ready  (dii_in_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period.
  end

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL time %0t %s expected %0h actual %0h", $time, name, exp, act);
    stop_run();
  endtask

  task automatic fail_run(input string why);
    $display("ERROR at time %0t: %s", $time, why);
    stop_run();
  endtask

  // one output ready per call, with optional long low phases.
  task automatic pick_ready(inout int stall, output logic rdy);
    if (stall > 0) begin
      stall--;
      rdy = 1'b0;
    end else if (ready_mode == 0) begin
      rdy = 1'b1;
    end else if (ready_mode == 2 && ($random(seed) & 31) == 0) begin
      stall = 20 + ($random(seed) & 15); // long enough to fill a buffer.
      rdy   = 1'b0;
    end else begin
      rdy = (($random(seed) & 3) != 0);  // high three times in four.
    end
  endtask

  always @(negedge clk) begin
    pick_ready(stall_ing, dii_out_ready);
    pick_ready(stall_egr, host_out_ready);
  end

  // handshake and scoreboard checks, pre-edge values.
  always @(posedge clk) begin
    rst_prev    <= rst;
    host_in_acc <= host_in.valid & host_in_ready;
    dii_in_acc  <= dii_in.valid & dii_in_ready;
    if (rst_prev) begin // in reset, or first cycle after it.
      assert (dii_out.valid === 1'b0) else fail_value("dii_out.valid", 0, dii_out.valid);
      assert (host_out.valid === 1'b0) else fail_value("host_out.valid", 0, host_out.valid);
      assert (host_in_ready === 1'b0) else fail_value("host_in_ready", 0, host_in_ready);
      assert (dii_in_ready === 1'b0) else fail_value("dii_in_ready", 0, dii_in_ready);
    end else begin
      if (dii_out.valid && dii_out_ready) begin
        if (ing_q.size() == 0) begin
          fail_run("dii_out sent a flit that no host packet asked for");
        end
        exp_flit = ing_q.pop_front();
        assert (dii_out.data === exp_flit[15:0])
          else fail_value("dii_out.data", exp_flit[15:0], dii_out.data);
        assert (dii_out.last === exp_flit[16])
          else fail_value("dii_out.last", exp_flit[16], dii_out.last);
      end
      if (host_out.valid && host_out_ready) begin
        if (egr_q.size() == 0) begin
          fail_run("host_out sent a word that no network packet asked for");
        end
        exp_word = egr_q.pop_front();
        assert (host_out.data.raw === exp_word)
          else fail_value("host_out.data", exp_word, host_out.data.raw);
      end
    end
  end

  // called at a falling edge, returns at the one after the transfer.
  task automatic put_host_word(input logic [15:0] word);
    int n;
    n                = 0;
    host_in.data.raw = word;
    host_in.valid    = 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        fail_run("host_in word was not accepted before the timeout");
      end
    end while (!host_in_acc);
    host_in.valid = 1'b0;
  endtask

  task automatic put_dii_flit(input logic [15:0] word, input logic last);
    int n;
    n            = 0;
    dii_in.data  = word;
    dii_in.last  = last;
    dii_in.valid = 1'b1;
    do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        fail_run("dii_in flit was not accepted before the timeout");
      end
    end while (!dii_in_acc);
    dii_in.valid = 1'b0;
  endtask

  // header word, then payload; slow adds idle gaps between words.
  task automatic send_host_packet(input int len, input bit slow);
    host_word_u  hdr;
    logic [15:0] word;
    int          i;
    hdr          = '0;
    hdr.hdr.size = HDR_SIZE_W'(len);
    put_host_word(hdr.raw);
    for (i = 0; i < len; i++) begin
      word = 16'($random(seed));
      ing_q.push_back({(i == len - 1), word}); // last on the final word only.
      put_host_word(word);
      if (slow) begin
        repeat (1 + ($random(seed) & 7)) @(negedge clk);
      end
    end
  endtask

  task automatic send_dii_packet(input int len, input bit slow);
    logic [15:0] word;
    int          i;
    egr_q.push_back(16'(len)); // size word, zero above the field.
    for (i = 0; i < len; i++) begin
      word = 16'($random(seed));
      egr_q.push_back(word);
      put_dii_flit(word, (i == len - 1));
      if (slow) begin
        repeat (1 + ($random(seed) & 7)) @(negedge clk);
      end
    end
  endtask

  // fixed_len of zero picks a random length.
  task automatic host_batch(input int count, input int fixed_len, input bit slow);
    int len;
    int k;
    for (k = 0; k < count; k++) begin
      len = fixed_len;
      if (len == 0) begin
        len = 1 + ($unsigned($random(seed)) % MAX_PKT_LEN);
      end
      send_host_packet(len, slow);
    end
  endtask

  task automatic dii_batch(input int count, input int fixed_len, input bit slow);
    int len;
    int k;
    for (k = 0; k < count; k++) begin
      len = fixed_len;
      if (len == 0) begin
        len = 1 + ($unsigned($random(seed)) % MAX_PKT_LEN);
      end
      send_dii_packet(len, slow);
    end
  endtask

  initial begin
    rst            = 1'b1;
    rst_prev       = 1'b0;
    host_in        = '0;
    dii_in         = '0;
    host_out_ready = 1'b1;
    dii_out_ready  = 1'b1;
    ready_mode     = 0;
    stall_ing      = 0;
    stall_egr      = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    fork // random framing both ways, outputs always ready.
      host_batch(10, 0, 1'b0);
      dii_batch(10, 0, 1'b0);
    join
    ready_mode = 1;
    fork // slow feed, nothing may leave before the last word.
      host_batch(4, 0, 1'b1);
      dii_batch(4, 0, 1'b1);
    join
    ready_mode = 2;
    fork // long stalls fill the buffers.
      host_batch(15, 0, 1'b0);
      dii_batch(15, 0, 1'b0);
    join
    ready_mode = 1;
    fork // maximum length, both directions at once.
      host_batch(4, MAX_PKT_LEN, 1'b0);
      dii_batch(4, MAX_PKT_LEN, 1'b0);
    join

    ready_mode = 0;
    waited     = 0;
    while (ing_q.size() != 0 || egr_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        fail_run("expected output words did not arrive before the timeout");
      end
    end
    repeat (20) @(negedge clk); // any extra word fails in the monitor.
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- osd_him_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// concurrent checks bound into osd_him.
// tracks host_in framing itself to know when a host packet is complete.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module osd_him_assert import dbg_pkg::*; (
  input logic         clk,
  input logic         rst,
  input host_stream_t host_in,
  input logic         host_in_ready,
  input host_stream_t host_out,
  input logic         host_out_ready,
  input dii_flit_t    dii_out,
  input logic         dii_out_ready,
  input logic         dii_in_ready
);

  logic                  in_pkt;     // inside a host packet's payload.
  logic [HDR_SIZE_W-1:0] words_left; // payload words still due, current one included.
  logic [7:0]            pkts_taken; // host packets whose final word was accepted.
  logic [7:0]            pkts_sent;  // packets gone out on dii_out.

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt     <= 1'b0;
      words_left <= '0;
      pkts_taken <= '0;
      pkts_sent  <= '0;
    end else begin
      if (host_in.valid && host_in_ready) begin
        if (!in_pkt) begin
          in_pkt     <= 1'b1;
          words_left <= host_in.data.hdr.size; // length word.
        end else if (words_left == HDR_SIZE_W'(1)) begin
          in_pkt     <= 1'b0;
          pkts_taken <= pkts_taken + 1'b1;     // final payload word.
        end else begin
          words_left <= words_left - 1'b1;
        end
      end
      if (dii_out.valid && dii_out_ready && dii_out.last) begin
        pkts_sent <= pkts_sent + 1'b1;
      end
    end
  end

  host_out_hold: assert property (@(posedge clk) disable iff (rst)
    (host_out.valid && !host_out_ready) |=> (host_out.valid && $stable(host_out.data)))
    else $error("host_out changed while stalled");

  dii_out_hold: assert property (@(posedge clk) disable iff (rst)
    (dii_out.valid && !dii_out_ready) |=> (dii_out.valid && $stable(dii_out.data)
      && $stable(dii_out.last)))
    else $error("dii_out changed while stalled");

  reset_quiet: assert property (@(posedge clk)
    rst |=> (!dii_out.valid && !host_out.valid && !host_in_ready && !dii_in_ready))
    else $error("outputs active in reset or just after");

  // a flit may only leave once its whole packet was taken on host_in.
  whole_packet: assert property (@(posedge clk) disable iff (rst)
    dii_out.valid |-> (pkts_taken != pkts_sent))
    else $error("dii_out valid before the host packet was complete");

endmodule

bind osd_him osd_him_assert u_osd_him_assert (
  .clk           (clk),
  .rst           (rst),
  .host_in       (host_in),
  .host_in_ready (host_in_ready),
  .host_out      (host_out),
  .host_out_ready(host_out_ready),
  .dii_out       (dii_out),
  .dii_out_ready (dii_out_ready),
  .dii_in_ready  (dii_in_ready)
);

`default_nettype wire

//--- osd_him.sv
// ~~~~~~~~~~~~~~~~~~~~
// debug host interface, host stream to debug network and back.
// MAX_PKT_LEN must be 1 .. 31 and sets both buffer depths.
// zero or oversize length words are not handled.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module osd_him import dbg_pkg::*; #(
  parameter int MAX_PKT_LEN = 12
) (
  input  logic         clk,
  input  logic         rst,

  input  host_stream_t host_in,        // length word, then payload.
  output logic         host_in_ready,
  output host_stream_t host_out,       // length word, then payload.
  input  logic         host_out_ready,

  output dii_flit_t    dii_out,
  input  logic         dii_out_ready,
  input  dii_flit_t    dii_in,
  output logic         dii_in_ready
);

  // the two directions share nothing but clock and reset.
  him_ingress #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) u_ingress (
    .clk          (clk),
    .rst          (rst),
    .host_in      (host_in),
    .host_in_ready(host_in_ready),
    .dii_out      (dii_out),
    .dii_out_ready(dii_out_ready)
  );

  him_egress #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) u_egress (
    .clk           (clk),
    .rst           (rst),
    .dii_in        (dii_in),
    .dii_in_ready  (dii_in_ready),
    .host_out      (host_out),
    .host_out_ready(host_out_ready)
  );

endmodule

`default_nettype wire

//--- him_egress.sv
// ~~~~~~~~~~~~~~~~~~~~
// network to host path: whole packets get a length word in front.
// packets must end with last within MAX_PKT_LEN flits.
// the length word carries the size in its low 5 bits, zero above.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module him_egress import dbg_pkg::*; #(
  parameter int MAX_PKT_LEN = 12
) (
  input  logic         clk,
  input  logic         rst,
  input  dii_flit_t    dii_in,
  output logic         dii_in_ready,
  output host_stream_t host_out,
  input  logic         host_out_ready
);

  localparam int CNT_W = len_w(MAX_PKT_LEN);

  dii_flit_t        buf_out;
  logic             buf_out_ready;
  logic [CNT_W-1:0] packet_size; // size of the packet at the buffer head.
  logic             active;      // header sent, payload going out.
  host_word_u       hdr_word;

  always_comb begin
    hdr_word          = '0;
    hdr_word.hdr.size = HDR_SIZE_W'(packet_size); // size always fits the field.
    host_out.valid    = buf_out.valid;            // header waits for a whole packet.
    if (active) begin
      host_out.data.raw = buf_out.data;
    end else begin
      host_out.data = hdr_word;
    end
  end

  // buffer only drains after the header went out.
  assign buf_out_ready = active & host_out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else if (!active) begin
      if (host_out.valid && host_out_ready) begin
        active <= 1'b1; // header taken.
      end
    end else if (buf_out.valid && buf_out_ready && buf_out.last) begin
      active <= 1'b0;   // packet done, next one gets a header.
    end
  end

  dii_packet_buffer #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) u_buffer (
    .clk           (clk),
    .rst           (rst),
    .flit_in       (dii_in),
    .flit_in_ready (dii_in_ready),
    .flit_out      (buf_out),
    .flit_out_ready(buf_out_ready),
    .packet_size   (packet_size)
  );

endmodule

`default_nettype wire

//--- him_ingress.sv
// ~~~~~~~~~~~~~~~~~~~~
// host to network path: length word, then that many payload words.
// the length word is dropped, payload becomes flits with last marked.
// length must be 1 .. MAX_PKT_LEN; other values are not recovered from.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module him_ingress import dbg_pkg::*; #(
  parameter int MAX_PKT_LEN = 12
) (
  input  logic         clk,
  input  logic         rst,
  input  host_stream_t host_in,
  output logic         host_in_ready,
  output dii_flit_t    dii_out,
  input  logic         dii_out_ready
);

  dii_flit_t             buf_in;
  logic                  buf_in_ready;
  logic                  active;    // inside a packet's payload.
  logic                  run;       // low through reset and one cycle after.
  logic [HDR_SIZE_W-1:0] remaining; // payload words after the current one.
  logic                  xfer;

  // idle takes any header, framing follows the buffer.
  assign host_in_ready = active ? buf_in_ready : run;
  assign xfer          = host_in.valid & host_in_ready;

  assign buf_in.data  = host_in.data.raw;
  assign buf_in.last  = active & (remaining == '0);
  assign buf_in.valid = active & host_in.valid; // header never reaches the buffer.

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      run       <= 1'b0;
      remaining <= '0;
    end else begin
      run <= 1'b1;
      if (xfer) begin
        if (!active) begin
          remaining <= host_in.data.hdr.size - 1'b1; // first payload word is next.
          active    <= 1'b1;
        end else begin
          remaining <= remaining - 1'b1;
          if (remaining == '0) begin
            active <= 1'b0; // last payload word taken.
          end
        end
      end
    end
  end

  dii_packet_buffer #(
    .MAX_PKT_LEN(MAX_PKT_LEN)
  ) u_buffer (
    .clk           (clk),
    .rst           (rst),
    .flit_in       (buf_in),
    .flit_in_ready (buf_in_ready),
    .flit_out      (dii_out),
    .flit_out_ready(dii_out_ready),
    .packet_size   ()
  );

endmodule

`default_nettype wire

//--- dii_packet_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// full-packet flit FIFO of MAX_PKT_LEN entries.
// a packet is shown at the output only once its last flit is written.
// a packet longer than MAX_PKT_LEN stalls the input for good.
// input ready is registered, so it is low in the first cycle after reset.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dii_packet_buffer import dbg_pkg::*; #(
  parameter int MAX_PKT_LEN = 12
) (
  input  logic                          clk,
  input  logic                          rst,
  input  dii_flit_t                     flit_in,
  output logic                          flit_in_ready,
  output dii_flit_t                     flit_out,
  input  logic                          flit_out_ready,
  output logic [len_w(MAX_PKT_LEN)-1:0] packet_size
);

  localparam int CNT_W = len_w(MAX_PKT_LEN);
  localparam int PTR_W = (MAX_PKT_LEN > 1) ? $clog2(MAX_PKT_LEN) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(MAX_PKT_LEN - 1);

  // stored flit, valid is implied by occupancy.
  typedef struct packed {
    logic [15:0] data;
    logic        last;
  } entry_t;

  entry_t           mem    [MAX_PKT_LEN]; // flit storage.
  logic [CNT_W-1:0] size_q [MAX_PKT_LEN]; // sizes of complete packets, oldest first.

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] sq_wr_ptr;
  logic [PTR_W-1:0] sq_rd_ptr;
  logic [CNT_W-1:0] fill;      // flits held.
  logic [CNT_W-1:0] fill_next;
  logic [CNT_W-1:0] pkt_cnt;   // complete packets held.
  logic [CNT_W-1:0] cur_size;  // flits of the packet still being written.
  logic             in_ready_q;
  logic             wr_en;
  logic             rd_en;
  logic             push;      // last flit written, packet complete.
  logic             pop;       // last flit read, packet gone.

  // pointers wrap at the depth, which need not be a power of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == LAST_IDX) ? '0 : p + 1'b1;
  endfunction

  assign wr_en = flit_in.valid & in_ready_q;
  assign rd_en = flit_out.valid & flit_out_ready;
  assign push  = wr_en & flit_in.last;
  assign pop   = rd_en & flit_out.last;

  assign flit_in_ready  = in_ready_q;
  assign flit_out.data  = mem[rd_ptr].data;
  assign flit_out.last  = mem[rd_ptr].last;
  assign flit_out.valid = (pkt_cnt != '0); // only whole packets leave.
  assign packet_size    = size_q[sq_rd_ptr];

  always_comb begin
    fill_next = fill;
    if (wr_en && !rd_en) begin
      fill_next = fill + 1'b1;
    end else if (rd_en && !wr_en) begin
      fill_next = fill - 1'b1;
    end
  end

  // storage, no reset needed on payload.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{data: flit_in.data, last: flit_in.last};
    end
    if (push) begin
      size_q[sq_wr_ptr] <= cur_size + 1'b1; // count includes the last flit.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      sq_wr_ptr  <= '0;
      sq_rd_ptr  <= '0;
      fill       <= '0;
      pkt_cnt    <= '0;
      cur_size   <= '0;
      in_ready_q <= 1'b0;
    end else begin
      fill       <= fill_next;
      in_ready_q <= (fill_next != CNT_W'(MAX_PKT_LEN)); // room for one more next cycle.
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (push) begin
        sq_wr_ptr <= ptr_inc(sq_wr_ptr);
        cur_size  <= '0;                  // next flit starts a new packet.
      end else if (wr_en) begin
        cur_size <= cur_size + 1'b1;
      end
      if (pop) begin
        sq_rd_ptr <= ptr_inc(sq_rd_ptr);  // next packet's size at the head.
      end
      case ({push, pop})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;      // none, or one in and one out.
      endcase
    end
  end

endmodule

`default_nettype wire

//--- dbg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared types for the debug host interface.
// host words and flits are 16 bits wide; the length header has a 5-bit size field.
// a length of zero or above the buffer depth is not handled and must not be sent.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package dbg_pkg;

  // width of the size field in a host length word.
  localparam int HDR_SIZE_W = 5;

  // length header view of a host word.
  typedef struct packed {
    logic [15-HDR_SIZE_W:0] rsvd; // must be zero.
    logic [HDR_SIZE_W-1:0]  size; // payload words that follow.
  } host_hdr_t;

  // one host word, either a length header or payload data.
  typedef union packed {
    logic [15:0] raw; // payload view.
    host_hdr_t   hdr; // length header view.
  } host_word_u;

  // host stream beat, ready travels back on its own wire.
  typedef struct packed {
    host_word_u data;
    logic       valid;
  } host_stream_t;

  // debug network flit.
  typedef struct packed {
    logic [15:0] data;
    logic        last;  // final flit of a packet.
    logic        valid;
  } dii_flit_t;

  // bits needed to count 0 .. max_len flits.
  function automatic int len_w(input int max_len);
    return $clog2(max_len) + 1;
  endfunction

endpackage

`default_nettype wire
